// ==== common/graph_params.svh ====
`ifndef GRAPH_PARAMS_SVH
`define GRAPH_PARAMS_SVH

////////////////////
// datapath widths
////////////////////

// vertex id and memory word address
`define GRAPH_VERTEX_BITS 16
`define GRAPH_ADDR_BITS 20
`define GRAPH_DATA_BITS 32

// in-degree limits the edge count per job
`define GRAPH_DEGREE_BITS 8

////////////////////
// cluster sizing
////////////////////

`define GRAPH_NUM_CU 3
`define GRAPH_JOB_DEPTH 8

`endif

// ==== common/graph_pkg.sv ====
`default_nettype none

`include "graph_params.svh"

package graph_pkg;

	////////////////////
	// job intake
	////////////////////

	// one vertex to process
	typedef struct packed {
		logic [`GRAPH_VERTEX_BITS-1:0] vertex_id;
		logic [`GRAPH_ADDR_BITS-1:0]   edge_base;
		logic [`GRAPH_DEGREE_BITS-1:0] degree;
	} vertex_job_t;

	// registered flags of the job buffer
	typedef struct packed {
		logic empty;
		logic full;
		logic almost_full;
	} buffer_status_t;

	////////////////////
	// memory command bus
	////////////////////

	typedef enum logic {
		READ  = 1'b0,
		WRITE = 1'b1
	} command_opcode_e;

	// data is only meaningful for writes
	typedef struct packed {
		command_opcode_e               opcode;
		logic [`GRAPH_ADDR_BITS-1:0]   address;
		logic [`GRAPH_DATA_BITS-1:0]   data;
	} command_t;

	// read data, valid while ack is high
	typedef struct packed {
		logic [`GRAPH_DATA_BITS-1:0] data;
	} response_t;

	////////////////////
	// compute unit FSM
	////////////////////

	// ISSUE states hold req high, WAIT states wait for ack to fall
	typedef enum logic [2:0] {
		IDLE        = 3'd0,
		FETCH_JOB   = 3'd1,
		ISSUE_READ  = 3'd2,
		WAIT_READ   = 3'd3,
		ISSUE_WRITE = 3'd4,
		WAIT_WRITE  = 3'd5
	} cu_state_e;

endpackage

`default_nettype wire

// ==== rtl/vertex_job_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "graph_params.svh"

module vertex_job_buffer (
	input  wire                              clock,
	input  wire                              rstn,
	input  wire                              job_push,
	input  wire graph_pkg::vertex_job_t      job_in,
	input  wire [`GRAPH_NUM_CU-1:0]          job_req,
	output logic [`GRAPH_NUM_CU-1:0]         job_grant,
	output graph_pkg::vertex_job_t           job_out,
	output graph_pkg::buffer_status_t        job_status
);

	localparam int DEPTH    = `GRAPH_JOB_DEPTH;
	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	graph_pkg::vertex_job_t mem [DEPTH];

	logic [PTR_BITS-1:0]      wr_ptr;
	logic [PTR_BITS-1:0]      rd_ptr;
	logic [CNT_BITS-1:0]      count;
	logic [CNT_BITS-1:0]      count_next;
	logic [`GRAPH_NUM_CU-1:0] req_open;
	logic [`GRAPH_NUM_CU-1:0] grant_next;
	logic                     push_ok;
	logic                     pop;

	// a unit still sees its own grant this cycle, so mask it out
	assign req_open   = job_req & ~job_grant;
	// lowest requesting unit wins
	assign grant_next = req_open & (~req_open + 1'b1);

	assign push_ok = job_push && !job_status.full;
	assign pop     = (|req_open) && !job_status.empty;

	always_comb begin
		count_next = count;
		if (push_ok && !pop) begin
			count_next = count + 1'b1;
		end else if (pop && !push_ok) begin
			count_next = count - 1'b1;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			job_grant  <= '0;
			job_status <= '{empty: 1'b1, full: 1'b0, almost_full: 1'b0};
		end else begin
			if (push_ok) begin
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			job_grant <= pop ? grant_next : '0;
			count     <= count_next;
			// flags follow the count after this cycle's push and pop
			job_status.empty       <= (count_next == '0);
			job_status.full        <= (count_next == CNT_BITS'(DEPTH));
			job_status.almost_full <= (count_next == CNT_BITS'(DEPTH - 1));
		end
	end

	// storage and hand-out register
	always_ff @(posedge clock) begin
		if (push_ok) begin
			mem[wr_ptr] <= job_in;
		end
		if (pop) begin
			job_out <= mem[rd_ptr];
		end
	end

endmodule

`default_nettype wire

// ==== vertex_cu/vertex_cu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "graph_params.svh"

module vertex_cu (
	input  wire                             clock,
	input  wire                             rstn,
	input  wire graph_pkg::buffer_status_t  job_status,
	output logic                            job_req,
	input  wire                             job_grant,
	input  wire graph_pkg::vertex_job_t     job_in,
	output logic                            cmd_req,
	output graph_pkg::command_t             cmd,
	input  wire                             cmd_ack,
	input  wire graph_pkg::response_t       rsp,
	output logic                            vertex_done
);

	graph_pkg::cu_state_e   state;
	graph_pkg::vertex_job_t job;

	logic [`GRAPH_DEGREE_BITS-1:0] edge_idx;
	logic [`GRAPH_DATA_BITS-1:0]   sum;

	logic take_job;
	logic rsp_take;
	logic launch_next;
	logic last_edge;

	graph_pkg::command_t first_cmd;
	graph_pkg::command_t read_cmd;
	graph_pkg::command_t write_cmd;

	function automatic graph_pkg::command_t make_cmd(
		input graph_pkg::command_opcode_e   opcode,
		input logic [`GRAPH_ADDR_BITS-1:0]  address,
		input logic [`GRAPH_DATA_BITS-1:0]  data
	);
		graph_pkg::command_t c;
		c.opcode  = opcode;
		c.address = address;
		c.data    = data;
		return c;
	endfunction

	////////////////////
	// handshake events
	////////////////////

	assign job_req     = (state == graph_pkg::FETCH_JOB);
	assign take_job    = (state == graph_pkg::FETCH_JOB) && job_grant;
	assign rsp_take    = (state == graph_pkg::ISSUE_READ) && cmd_ack;
	assign launch_next = (state == graph_pkg::WAIT_READ) && !cmd_ack;
	// edge_idx has already moved past the edge just read
	assign last_edge   = (edge_idx == job.degree);

	// write handshake is over once ack falls
	assign vertex_done = (state == graph_pkg::WAIT_WRITE) && !cmd_ack;

	// zero-degree vertex writes zero straight away
	assign first_cmd = (job_in.degree == '0) ?
		make_cmd(graph_pkg::WRITE, `GRAPH_ADDR_BITS'(job_in.vertex_id), '0) :
		make_cmd(graph_pkg::READ, job_in.edge_base, '0);

	assign read_cmd  = make_cmd(graph_pkg::READ,
		job.edge_base + `GRAPH_ADDR_BITS'(edge_idx), '0);
	assign write_cmd = make_cmd(graph_pkg::WRITE,
		`GRAPH_ADDR_BITS'(job.vertex_id), sum);

	////////////////////
	// FSM
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state    <= graph_pkg::IDLE;
			cmd_req  <= 1'b0;
			edge_idx <= '0;
		end else begin
			case (state)
				graph_pkg::IDLE: begin
					if (!job_status.empty) begin
						state <= graph_pkg::FETCH_JOB;
					end
				end
				graph_pkg::FETCH_JOB: begin
					// grant wins even if the buffer just went empty
					if (job_grant) begin
						cmd_req  <= 1'b1;
						edge_idx <= '0;
						state    <= (job_in.degree == '0) ?
							graph_pkg::ISSUE_WRITE : graph_pkg::ISSUE_READ;
					end else if (job_status.empty) begin
						state <= graph_pkg::IDLE;
					end
				end
				graph_pkg::ISSUE_READ: begin
					if (cmd_ack) begin
						cmd_req  <= 1'b0;
						edge_idx <= edge_idx + 1'b1;
						state    <= graph_pkg::WAIT_READ;
					end
				end
				graph_pkg::WAIT_READ: begin
					if (!cmd_ack) begin
						cmd_req <= 1'b1;
						state   <= last_edge ?
							graph_pkg::ISSUE_WRITE : graph_pkg::ISSUE_READ;
					end
				end
				graph_pkg::ISSUE_WRITE: begin
					if (cmd_ack) begin
						cmd_req <= 1'b0;
						state   <= graph_pkg::WAIT_WRITE;
					end
				end
				graph_pkg::WAIT_WRITE: begin
					if (!cmd_ack) begin
						state <= graph_pkg::IDLE;
					end
				end
				default: state <= graph_pkg::IDLE;
			endcase
		end
	end

	// job, accumulator and command payload
	always_ff @(posedge clock) begin
		if (take_job) begin
			job <= job_in;
			sum <= '0;
			cmd <= first_cmd;
		end
		if (rsp_take) begin
			// wraps on overflow
			sum <= sum + rsp.data;
		end
		if (launch_next) begin
			cmd <= last_edge ? write_cmd : read_cmd;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/command_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "graph_params.svh"

module command_arbiter (
	input  wire                                   clock,
	input  wire                                   rstn,
	input  wire [`GRAPH_NUM_CU-1:0]               cu_cmd_req,
	input  wire graph_pkg::command_t [`GRAPH_NUM_CU-1:0] cu_cmd,
	output logic [`GRAPH_NUM_CU-1:0]              cu_cmd_ack,
	output graph_pkg::response_t                  cu_rsp,
	output logic                                  mem_cmd_req,
	output graph_pkg::command_t                   mem_cmd,
	input  wire                                   mem_cmd_ack,
	input  wire graph_pkg::response_t             mem_rsp
);

	localparam int NUM_CU   = `GRAPH_NUM_CU;
	localparam int IDX_BITS = (NUM_CU > 1) ? $clog2(NUM_CU) : 1;

	// relay phases of one granted transfer
	typedef enum logic [1:0] {
		ARB_IDLE    = 2'd0,
		ARB_REQ     = 2'd1,
		ARB_RELAY   = 2'd2,
		ARB_RELEASE = 2'd3
	} arb_state_e;

	arb_state_e          state;
	logic [IDX_BITS-1:0] grant_idx;
	logic [IDX_BITS-1:0] rr_ptr;
	logic [IDX_BITS-1:0] pick_idx;
	logic                pick_valid;

	// scan from rr_ptr upward, closest requester wins
	always_comb begin
		int cand;
		pick_idx   = '0;
		pick_valid = 1'b0;
		for (int k = NUM_CU - 1; k >= 0; k--) begin
			cand = int'(rr_ptr) + k;
			if (cand >= NUM_CU) begin
				cand = cand - NUM_CU;
			end
			if (cu_cmd_req[cand]) begin
				pick_idx   = IDX_BITS'(cand);
				pick_valid = 1'b1;
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state       <= ARB_IDLE;
			grant_idx   <= '0;
			rr_ptr      <= '0;
			mem_cmd_req <= 1'b0;
			cu_cmd_ack  <= '0;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (pick_valid) begin
						grant_idx   <= pick_idx;
						mem_cmd_req <= 1'b1;
						state       <= ARB_REQ;
					end
				end
				ARB_REQ: begin
					if (mem_cmd_ack) begin
						cu_cmd_ack[grant_idx] <= 1'b1;
						state                 <= ARB_RELAY;
					end
				end
				ARB_RELAY: begin
					if (!cu_cmd_req[grant_idx]) begin
						mem_cmd_req <= 1'b0;
						state       <= ARB_RELEASE;
					end
				end
				ARB_RELEASE: begin
					// unit ack falls together with the memory ack
					if (!mem_cmd_ack) begin
						cu_cmd_ack <= '0;
						rr_ptr     <= (grant_idx == IDX_BITS'(NUM_CU - 1)) ?
							'0 : grant_idx + 1'b1;
						state      <= ARB_IDLE;
					end
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	// command and read data registers
	always_ff @(posedge clock) begin
		if ((state == ARB_IDLE) && pick_valid) begin
			mem_cmd <= cu_cmd[pick_idx];
		end
		if ((state == ARB_REQ) && mem_cmd_ack) begin
			cu_rsp <= mem_rsp;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/graph_cu_cluster.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "graph_params.svh"

module graph_cu_cluster (
	input  wire                              clock,
	input  wire                              rstn,
	input  wire                              job_push,
	input  wire graph_pkg::vertex_job_t      job_in,
	output graph_pkg::buffer_status_t        job_status,
	output logic                             mem_cmd_req,
	output graph_pkg::command_t              mem_cmd,
	input  wire                              mem_cmd_ack,
	input  wire graph_pkg::response_t        mem_rsp,
	output logic [`GRAPH_VERTEX_BITS-1:0]    vertex_done_count
);

	logic [`GRAPH_NUM_CU-1:0]                job_req;
	logic [`GRAPH_NUM_CU-1:0]                job_grant;
	graph_pkg::vertex_job_t                  job_out;
	logic [`GRAPH_NUM_CU-1:0]                cu_cmd_req;
	graph_pkg::command_t [`GRAPH_NUM_CU-1:0] cu_cmd;
	logic [`GRAPH_NUM_CU-1:0]                cu_cmd_ack;
	graph_pkg::response_t                    cu_rsp;
	logic [`GRAPH_NUM_CU-1:0]                vertex_done;
	logic [`GRAPH_VERTEX_BITS-1:0]           done_sum;

	vertex_job_buffer u_job_buffer (
		.clock      (clock),
		.rstn       (rstn),
		.job_push   (job_push),
		.job_in     (job_in),
		.job_req    (job_req),
		.job_grant  (job_grant),
		.job_out    (job_out),
		.job_status (job_status)
	);

	for (genvar i = 0; i < `GRAPH_NUM_CU; i++) begin : g_cu
		vertex_cu u_cu (
			.clock       (clock),
			.rstn        (rstn),
			.job_status  (job_status),
			.job_req     (job_req[i]),
			.job_grant   (job_grant[i]),
			.job_in      (job_out),
			.cmd_req     (cu_cmd_req[i]),
			.cmd         (cu_cmd[i]),
			.cmd_ack     (cu_cmd_ack[i]),
			.rsp         (cu_rsp),
			.vertex_done (vertex_done[i])
		);
	end

	command_arbiter u_arbiter (
		.clock       (clock),
		.rstn        (rstn),
		.cu_cmd_req  (cu_cmd_req),
		.cu_cmd      (cu_cmd),
		.cu_cmd_ack  (cu_cmd_ack),
		.cu_rsp      (cu_rsp),
		.mem_cmd_req (mem_cmd_req),
		.mem_cmd     (mem_cmd),
		.mem_cmd_ack (mem_cmd_ack),
		.mem_rsp     (mem_rsp)
	);

	////////////////////
	// completed vertices
	////////////////////

	// more than one unit can finish in the same cycle
	always_comb begin
		done_sum = '0;
		for (int i = 0; i < `GRAPH_NUM_CU; i++) begin
			done_sum = done_sum + `GRAPH_VERTEX_BITS'(vertex_done[i]);
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_done_count <= '0;
		end else begin
			vertex_done_count <= vertex_done_count + done_sum;
		end
	end

endmodule

`default_nettype wire

// ==== tb/graph_cu_cluster_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "graph_params.svh"

module graph_cu_cluster_tb;

	localparam int MAX_DEG     = 12;
	localparam int RANDOM_JOBS = 24;
	localparam int MAX_JOBS    = 64;
	localparam int VID_SPACE   = 1024;
	localparam int HOLD_CYCLES = 150;
	localparam int BP_LIMIT    = `GRAPH_NUM_CU + `GRAPH_JOB_DEPTH;
	// every command takes well under 16 cycles on the shared bus
	localparam int CYCLE_LIMIT = (RANDOM_JOBS + BP_LIMIT) * (MAX_DEG + 1) * 16
		+ HOLD_CYCLES + 2000;

	logic                          clock;
	logic                          rstn;
	logic                          job_push;
	graph_pkg::vertex_job_t        job_in;
	graph_pkg::buffer_status_t     job_status;
	logic                          mem_cmd_req;
	graph_pkg::command_t           mem_cmd;
	logic                          mem_cmd_ack;
	graph_pkg::response_t          mem_rsp;
	logic [`GRAPH_VERTEX_BITS-1:0] vertex_done_count;

	int stim_seed = 8229;
	int mem_seed  = 8229;

	// pushed jobs and their progress
	graph_pkg::vertex_job_t jobs [MAX_JOBS];
	logic [15:0]            read_mask [MAX_JOBS];
	logic                   job_written [MAX_JOBS];
	int                     num_jobs;

	// memory side record of writes
	int          write_count [VID_SPACE];
	logic [31:0] write_data [VID_SPACE];
	int          total_writes;

	int   value_errors;
	int   other_errors;
	int   cycle_count;
	logic hold_acks;

	graph_cu_cluster UUT (
		.clock             (clock),
		.rstn              (rstn),
		.job_push          (job_push),
		.job_in            (job_in),
		.job_status        (job_status),
		.mem_cmd_req       (mem_cmd_req),
		.mem_cmd           (mem_cmd),
		.mem_cmd_ack       (mem_cmd_ack),
		.mem_rsp           (mem_rsp),
		.vertex_done_count (vertex_done_count)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	////////////////////
	// reference model
	////////////////////

	function automatic logic [31:0] contribution(input logic [`GRAPH_ADDR_BITS-1:0] addr);
		logic [31:0] a;
		a = 32'(addr);
		return (a * 32'h9e3779b1) ^ (a << 11) ^ 32'h5a5a0f0f;
	endfunction

	function automatic logic [31:0] expected_sum(input graph_pkg::vertex_job_t job);
		logic [31:0] s;
		s = '0;
		for (int k = 0; k < int'(job.degree); k++) begin
			s = s + contribution(job.edge_base + `GRAPH_ADDR_BITS'(k));
		end
		return s;
	endfunction

	// edge ranges 32 words apart never overlap
	function automatic graph_pkg::vertex_job_t make_job(input int idx, input int deg,
		input int offset);
		graph_pkg::vertex_job_t j;
		j.vertex_id = `GRAPH_VERTEX_BITS'(idx * 7 + 5);
		j.edge_base = `GRAPH_ADDR_BITS'(32'h1000 + idx * 32 + offset);
		j.degree    = `GRAPH_DEGREE_BITS'(deg);
		return j;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic note_failure(input string msg);
		$display("failure at cycle %0d: %s", cycle_count, msg);
		other_errors++;
	endtask

	task automatic check_read(input logic [`GRAPH_ADDR_BITS-1:0] addr);
		int found;
		int k;
		found = -1;
		for (int j = 0; j < num_jobs; j++) begin
			if (!job_written[j] && int'(addr) >= int'(jobs[j].edge_base)
				&& int'(addr) < int'(jobs[j].edge_base) + int'(jobs[j].degree)) begin
				found = j;
			end
		end
		if (found < 0) begin
			note_failure($sformatf("read at address %0h matches no pending job edge", addr));
		end else begin
			k = int'(addr) - int'(jobs[found].edge_base);
			if (read_mask[found][k]) begin
				note_failure($sformatf("edge %0d of vertex %0d was read twice", k,
					jobs[found].vertex_id));
			end
			read_mask[found][k] = 1'b1;
		end
	endtask

	task automatic check_write(input logic [`GRAPH_ADDR_BITS-1:0] addr,
		input logic [31:0] data);
		int found;
		found = -1;
		for (int j = 0; j < num_jobs; j++) begin
			if (!job_written[j] && `GRAPH_ADDR_BITS'(jobs[j].vertex_id) == addr) begin
				found = j;
			end
		end
		if (found < 0) begin
			note_failure($sformatf("write to address %0h has no pending job", addr));
		end else begin
			check_value($sformatf("write value vertex %0d", addr), expected_sum(jobs[found]),
				data);
			if (read_mask[found] != 16'((32'd1 << jobs[found].degree) - 1)) begin
				note_failure($sformatf("vertex %0d written before all edges were read", addr));
			end
			job_written[found] = 1'b1;
		end
	endtask

	task automatic push_job(input graph_pkg::vertex_job_t job);
		jobs[num_jobs]        = job;
		read_mask[num_jobs]   = '0;
		job_written[num_jobs] = 1'b0;
		num_jobs++;
		job_push <= 1'b1;
		job_in   <= job;
		@(posedge clock);
		job_push <= 1'b0;
	endtask

	task automatic wait_for_done(input int target);
		while (int'(vertex_done_count) != target) begin
			@(posedge clock);
		end
	endtask

	////////////////////
	// memory responder
	////////////////////

	int ack_wait;
	int ack_delay;

	always @(posedge clock) begin
		if (rstn && mem_cmd_req && !mem_cmd_ack && !hold_acks) begin
			if (ack_wait >= ack_delay) begin
				mem_cmd_ack  <= 1'b1;
				mem_rsp.data <= (mem_cmd.opcode == graph_pkg::READ) ?
					contribution(mem_cmd.address) : 32'h0;
				if (mem_cmd.opcode == graph_pkg::WRITE && int'(mem_cmd.address) < VID_SPACE) begin
					write_count[mem_cmd.address]++;
					write_data[mem_cmd.address] = mem_cmd.data;
				end
				ack_wait  = 0;
				ack_delay = int'($unsigned($random(mem_seed)) % 6);
			end else begin
				ack_wait++;
			end
		end else if (!mem_cmd_req && mem_cmd_ack) begin
			mem_cmd_ack <= 1'b0;
		end
	end

	////////////////////
	// bus compare
	////////////////////

	logic                req_prev;
	graph_pkg::command_t cmd_prev;

	always @(posedge clock) begin
		if (rstn) begin
			if (mem_cmd_req && req_prev && mem_cmd != cmd_prev) begin
				note_failure("protocol failure, mem_cmd changed while mem_cmd_req was high");
			end
			if (mem_cmd_req && !req_prev) begin
				if (mem_cmd_ack) begin
					note_failure("protocol failure, mem_cmd_req rose while mem_cmd_ack was high");
				end
				if (mem_cmd.opcode == graph_pkg::READ) begin
					check_read(mem_cmd.address);
				end else begin
					total_writes++;
					check_write(mem_cmd.address, mem_cmd.data);
				end
			end
		end
		req_prev = mem_cmd_req;
		cmd_prev = mem_cmd;
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Test failed");
			$finish;
		end
	end

	////////////////////
	// main sequence
	////////////////////

	initial begin
		int deg;
		int gap;
		int bp_pushed;
		int writes_before;
		int vid;
		logic last_almost;
		rstn         = 1'b0;
		job_push     = 1'b0;
		job_in       = '0;
		mem_cmd_ack  = 1'b0;
		mem_rsp      = '0;
		hold_acks    = 1'b0;
		num_jobs     = 0;
		total_writes = 0;
		value_errors = 0;
		other_errors = 0;
		cycle_count  = 0;
		ack_wait     = 0;
		ack_delay    = 0;
		req_prev     = 1'b0;
		cmd_prev     = '0;
		last_almost  = 1'b0;
		for (int v = 0; v < VID_SPACE; v++) begin
			write_count[v] = 0;
			write_data[v]  = '0;
		end
		repeat (10) @(posedge clock);
		rstn <= 1'b1;
		@(posedge clock);
		check_value("reset done count", 32'd0, 32'(vertex_done_count));
		check_value("reset empty flag", 32'd1, 32'(job_status.empty));
		check_value("reset almost full flag", 32'd0, 32'(job_status.almost_full));
		check_value("reset mem_cmd_req", 32'd0, 32'(mem_cmd_req));

		// random jobs, every sixth one has no edges
		for (int i = 0; i < RANDOM_JOBS; i++) begin
			deg = (i % 6 == 0) ? 0 : 1 + int'($unsigned($random(stim_seed)) % MAX_DEG);
			gap = int'($unsigned($random(stim_seed)) % 4);
			repeat (gap) @(posedge clock);
			@(posedge clock);
			while (job_status.full) begin
				@(posedge clock);
			end
			push_job(make_job(num_jobs, deg, int'($unsigned($random(stim_seed)) % 16)));
		end
		wait_for_done(num_jobs);

		// back-pressure with the memory silent
		hold_acks     <= 1'b1;
		writes_before = total_writes;
		bp_pushed     = 0;
		@(posedge clock);
		while (!job_status.full && bp_pushed < BP_LIMIT) begin
			deg = 1 + int'($unsigned($random(stim_seed)) % MAX_DEG);
			push_job(make_job(num_jobs, deg, int'($unsigned($random(stim_seed)) % 16)));
			bp_pushed++;
			@(posedge clock);
			// one slot left just before the buffer fills
			if (!job_status.full) begin
				last_almost = job_status.almost_full;
			end
		end
		if (!job_status.full) begin
			note_failure($sformatf("job buffer not full after %0d pushes", bp_pushed));
		end else begin
			check_value("almost full before last push", 32'd1, 32'(last_almost));
			check_value("almost full while full", 32'd0, 32'(job_status.almost_full));
		end
		repeat (HOLD_CYCLES) @(posedge clock);
		check_value("writes while acks held", 32'(writes_before), 32'(total_writes));
		check_value("done count while acks held", 32'(num_jobs - bp_pushed),
			32'(vertex_done_count));
		hold_acks <= 1'b0;
		wait_for_done(num_jobs);
		repeat (4) @(posedge clock);

		for (int j = 0; j < num_jobs; j++) begin
			vid = int'(jobs[j].vertex_id);
			check_value($sformatf("write count vertex %0d", vid), 32'd1, 32'(write_count[vid]));
			check_value($sformatf("stored sum vertex %0d", vid), expected_sum(jobs[j]),
				write_data[vid]);
		end
		check_value("final done count", 32'(num_jobs), 32'(vertex_done_count));

		$display("%0d jobs, %0d value errors, %0d other failures", num_jobs, value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== graph_cu_cluster.f ====
+incdir+common
common/graph_pkg.sv
rtl/vertex_job_buffer.sv
vertex_cu/vertex_cu.sv
rtl/command_arbiter.sv
rtl/graph_cu_cluster.sv
tb/graph_cu_cluster_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the graph cluster testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=graph_cu_cluster_sim

verilator --binary --timing -Wno-fatal \
	-f graph_cu_cluster.f \
	--top-module graph_cu_cluster_tb \
	-o "$BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" "$LOG"; then
	exit 1
fi
exit 0
